/* io_pkg.sv */
// address map, register offsets and widths shared by the IO port controller
// peripherals get one register-access bundle and decode their own offset
// UART bit time is very short so that frames stay short in simulation
package io_pkg;

	// CPU bus
	localparam int DATA_BITS = 16;
	localparam int ADDR_BITS = 16;
	localparam int REG_ADDR_BITS = 4;
	localparam int SEL_BITS = 4;   // top nibble of the address

	// peripheral selects, same map as the full system
	localparam logic [SEL_BITS-1:0] SEL_UART = 4'h0;
	localparam logic [SEL_BITS-1:0] SEL_GPIO = 4'h1;
	localparam logic [SEL_BITS-1:0] SEL_PWM = 4'h2;
	localparam logic [SEL_BITS-1:0] SEL_IRQ = 4'h7;

	// pins
	localparam int GPIO_OUT_BITS = 4;
	localparam int GPIO_IN_BITS = 6;
	localparam int PWM_BITS = 8;

	// interrupt sources
	localparam int IRQ_COUNT = 3;
	localparam int IRQ_GPIO = 0;
	localparam int IRQ_UART = 1;
	localparam int IRQ_PWM = 2;

	// UART timing
	localparam int CLKS_PER_BIT = 16;
	localparam int UART_DIV_BITS = $clog2(CLKS_PER_BIT);
	localparam int UART_FRAME_BITS = 10;   // start, 8 data, stop
	localparam int UART_CNT_BITS = $clog2(UART_FRAME_BITS);

	// register offsets per peripheral
	localparam logic [REG_ADDR_BITS-1:0] REG_UART_DATA = 4'd0;
	localparam logic [REG_ADDR_BITS-1:0] REG_UART_STATUS = 4'd1;

	localparam logic [REG_ADDR_BITS-1:0] REG_GPIO_OUT = 4'd0;
	localparam logic [REG_ADDR_BITS-1:0] REG_GPIO_IN = 4'd1;
	localparam logic [REG_ADDR_BITS-1:0] REG_GPIO_MASK = 4'd2;

	localparam logic [REG_ADDR_BITS-1:0] REG_PWM_R = 4'd0;
	localparam logic [REG_ADDR_BITS-1:0] REG_PWM_G = 4'd1;
	localparam logic [REG_ADDR_BITS-1:0] REG_PWM_B = 4'd2;

	localparam logic [REG_ADDR_BITS-1:0] REG_IRQ_PENDING = 4'd0;
	localparam logic [REG_ADDR_BITS-1:0] REG_IRQ_ENABLE = 4'd1;

	// bundle the controller drives to every peripheral
	typedef struct packed {
		logic [REG_ADDR_BITS-1:0] reg_addr;
		logic [DATA_BITS-1:0] wdata;
	} reg_access_t;

endpackage

/* gpio.sv */
// GPIO block with an output register, a mask and a level interrupt
// inputs pass through two flops, so changes show two cycles late
`timescale 1ns/1ns

module gpio (
	input  logic CLK,
	input  logic RSTb,
	input  io_pkg::reg_access_t acc,
	input  logic wr,
	output logic [io_pkg::DATA_BITS-1:0] rdata,
	output logic [io_pkg::GPIO_OUT_BITS-1:0] gpio_out,
	input  logic [io_pkg::GPIO_IN_BITS-1:0] gpio_in,
	output logic gpio_int
);
	import io_pkg::*;

	logic [GPIO_OUT_BITS-1:0] out_q;
	logic [GPIO_IN_BITS-1:0] mask_q;
	logic [GPIO_IN_BITS-1:0] sync1_q;
	logic [GPIO_IN_BITS-1:0] sync2_q;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			out_q <= '0;
			mask_q <= '0;
			sync1_q <= '0;
			sync2_q <= '0;
		end else begin
			sync1_q <= gpio_in;
			sync2_q <= sync1_q;
			if (wr && acc.reg_addr == REG_GPIO_OUT)
				out_q <= acc.wdata[GPIO_OUT_BITS-1:0];
			if (wr && acc.reg_addr == REG_GPIO_MASK)
				mask_q <= acc.wdata[GPIO_IN_BITS-1:0];
		end
	end

	assign gpio_out = out_q;

	// level interrupt while any enabled input is high
	assign gpio_int = |(sync2_q & mask_q);

	always_comb begin
		case (acc.reg_addr)
			REG_GPIO_OUT: rdata = DATA_BITS'(out_q);
			REG_GPIO_IN: rdata = DATA_BITS'(sync2_q);
			REG_GPIO_MASK: rdata = DATA_BITS'(mask_q);
			default: rdata = '0;
		endcase
	end

endmodule

/* pwm_led.sv */
// three-channel PWM for the RGB LED, one shared 256-step counter
// a channel is high for exactly duty cycles out of 256, duty 0 is off
// period_wrap marks the last count of each period
`timescale 1ns/1ns

module pwm_led (
	input  logic CLK,
	input  logic RSTb,
	input  io_pkg::reg_access_t acc,
	input  logic wr,
	output logic [io_pkg::DATA_BITS-1:0] rdata,
	output logic led_r,
	output logic led_g,
	output logic led_b,
	output logic period_wrap
);
	import io_pkg::*;

	typedef struct packed {
		logic [PWM_BITS-1:0] r;
		logic [PWM_BITS-1:0] g;
		logic [PWM_BITS-1:0] b;
	} rgb_duty_t;

	rgb_duty_t duty_q;
	logic [PWM_BITS-1:0] cnt_q;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			duty_q <= '0;
			cnt_q <= '0;
		end else begin
			cnt_q <= cnt_q + 1'b1;   // free running, wraps at 255
			if (wr) begin
				case (acc.reg_addr)
					REG_PWM_R: duty_q.r <= acc.wdata[PWM_BITS-1:0];
					REG_PWM_G: duty_q.g <= acc.wdata[PWM_BITS-1:0];
					REG_PWM_B: duty_q.b <= acc.wdata[PWM_BITS-1:0];
					default: ;
				endcase
			end
		end
	end

	assign led_r = cnt_q < duty_q.r;
	assign led_g = cnt_q < duty_q.g;
	assign led_b = cnt_q < duty_q.b;
	assign period_wrap = &cnt_q;

	// duties read back in the low byte
	always_comb begin
		case (acc.reg_addr)
			REG_PWM_R: rdata = DATA_BITS'(duty_q.r);
			REG_PWM_G: rdata = DATA_BITS'(duty_q.g);
			REG_PWM_B: rdata = DATA_BITS'(duty_q.b);
			default: rdata = '0;
		endcase
	end

endmodule

/* uart_tx.sv */
// UART transmitter, 8N1, CLKS_PER_BIT cycles per bit
// a data write while busy is dropped, poll status bit 0 first
// tx_done pulses one cycle after the stop bit ends
`timescale 1ns/1ns

module uart_tx (
	input  logic CLK,
	input  logic RSTb,
	input  io_pkg::reg_access_t acc,
	input  logic wr,
	output logic [io_pkg::DATA_BITS-1:0] rdata,
	output logic uart_tx,
	output logic tx_done
);
	import io_pkg::*;

	logic busy_q;
	logic tx_q;
	logic done_q;
	logic [UART_DIV_BITS-1:0] div_q;
	logic [UART_CNT_BITS-1:0] bit_q;
	logic [UART_FRAME_BITS-2:0] shift_q;   // data bits then stop bit
	logic start;
	logic bit_end;

	assign start = wr && (acc.reg_addr == REG_UART_DATA) && !busy_q;
	assign bit_end = busy_q && (div_q == UART_DIV_BITS'(CLKS_PER_BIT - 1));

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			busy_q <= 1'b0;
			tx_q <= 1'b1;   // line idles high
			done_q <= 1'b0;
			div_q <= '0;
			bit_q <= '0;
		end else begin
			done_q <= 1'b0;
			if (start) begin
				busy_q <= 1'b1;
				tx_q <= 1'b0;   // start bit
				div_q <= '0;
				bit_q <= '0;
			end else if (busy_q) begin
				div_q <= div_q + 1'b1;
				if (bit_end) begin
					div_q <= '0;
					if (bit_q == UART_CNT_BITS'(UART_FRAME_BITS - 1)) begin
						busy_q <= 1'b0;   // stop bit done
						done_q <= 1'b1;
						tx_q <= 1'b1;
					end else begin
						tx_q <= shift_q[0];
						bit_q <= bit_q + 1'b1;
					end
				end
			end
		end
	end

	// payload shifts out LSB first, ones fill from the top
	always_ff @(posedge CLK) begin
		if (start)
			shift_q <= {1'b1, acc.wdata[UART_FRAME_BITS-3:0]};
		else if (bit_end)
			shift_q <= {1'b1, shift_q[UART_FRAME_BITS-2:1]};
	end

	assign uart_tx = tx_q;
	assign tx_done = done_q;

	always_comb begin
		rdata = '0;
		if (acc.reg_addr == REG_UART_STATUS)
			rdata[0] = busy_q;
	end

	a_idle_high: assert property (@(posedge CLK) disable iff (!RSTb)
		!busy_q |-> uart_tx);

endmodule

/* interrupt_controller.sv */
// collects peripheral events into pending bits on their rising edge
// writing ones to pending clears them, a new edge in the same cycle wins
// irq and interrupt are registered, one cycle behind pending
`timescale 1ns/1ns

module interrupt_controller (
	input  logic CLK,
	input  logic RSTb,
	input  io_pkg::reg_access_t acc,
	input  logic wr,
	output logic [io_pkg::DATA_BITS-1:0] rdata,
	input  logic [io_pkg::IRQ_COUNT-1:0] sources,
	output logic [io_pkg::IRQ_COUNT-1:0] irq,
	output logic interrupt
);
	import io_pkg::*;

	logic [IRQ_COUNT-1:0] src_q;
	logic [IRQ_COUNT-1:0] pending_q;
	logic [IRQ_COUNT-1:0] enable_q;
	logic [IRQ_COUNT-1:0] irq_q;
	logic int_q;
	logic [IRQ_COUNT-1:0] rise;
	logic [IRQ_COUNT-1:0] clr;

	assign rise = sources & ~src_q;
	assign clr = (wr && acc.reg_addr == REG_IRQ_PENDING) ? acc.wdata[IRQ_COUNT-1:0] : '0;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			src_q <= '0;
			pending_q <= '0;
			enable_q <= '0;
			irq_q <= '0;
			int_q <= 1'b0;
		end else begin
			src_q <= sources;
			pending_q <= (pending_q & ~clr) | rise;
			if (wr && acc.reg_addr == REG_IRQ_ENABLE)
				enable_q <= acc.wdata[IRQ_COUNT-1:0];
			irq_q <= pending_q & enable_q;
			int_q <= |(pending_q & enable_q);
		end
	end

	assign irq = irq_q;
	assign interrupt = int_q;

	always_comb begin
		case (acc.reg_addr)
			REG_IRQ_PENDING: rdata = DATA_BITS'(pending_q);
			REG_IRQ_ENABLE: rdata = DATA_BITS'(enable_q);
			default: rdata = '0;
		endcase
	end

	a_int_is_or: assert property (@(posedge CLK) disable iff (!RSTb)
		interrupt == |irq);

endmodule

/* port_controller.sv */
// memory-mapped IO controller for the 16-bit CPU bus
// reads return registered data one cycle after the address, writes take one edge
// only UART, GPIO, PWM and the interrupt controller are mapped
// every other range reads as zero and ignores writes
`timescale 1ns/1ns

module port_controller (
	input  logic CLK,
	input  logic RSTb,
	input  logic [io_pkg::ADDR_BITS-1:0] addr,
	input  logic [io_pkg::DATA_BITS-1:0] wdata,
	input  logic mem_wr,
	input  logic mem_rd,
	output logic [io_pkg::DATA_BITS-1:0] rdata,
	input  logic [io_pkg::GPIO_IN_BITS-1:0] gpio_in,
	output logic [io_pkg::GPIO_OUT_BITS-1:0] gpio_out,
	output logic led_r,
	output logic led_g,
	output logic led_b,
	output logic uart_tx,
	output logic [io_pkg::IRQ_COUNT-1:0] irq,
	output logic interrupt
);
	import io_pkg::*;

	reg_access_t acc;
	logic [SEL_BITS-1:0] sel;
	logic wr_uart;
	logic wr_gpio;
	logic wr_pwm;
	logic wr_irq;
	logic [DATA_BITS-1:0] rd_uart;
	logic [DATA_BITS-1:0] rd_gpio;
	logic [DATA_BITS-1:0] rd_pwm;
	logic [DATA_BITS-1:0] rd_irq;
	logic [DATA_BITS-1:0] rd_mux;
	logic gpio_int;
	logic tx_done;
	logic period_wrap;
	logic [IRQ_COUNT-1:0] irq_src;

	assign sel = addr[ADDR_BITS-1 -: SEL_BITS];
	assign acc = '{reg_addr: addr[REG_ADDR_BITS-1:0], wdata: wdata};

	// decode stage, one strobe and one read source per range
	always_comb begin
		wr_uart = 1'b0;
		wr_gpio = 1'b0;
		wr_pwm = 1'b0;
		wr_irq = 1'b0;
		rd_mux = '0;   // unmapped
		case (sel)
			SEL_UART: begin
				wr_uart = mem_wr;
				rd_mux = rd_uart;
			end
			SEL_GPIO: begin
				wr_gpio = mem_wr;
				rd_mux = rd_gpio;
			end
			SEL_PWM: begin
				wr_pwm = mem_wr;
				rd_mux = rd_pwm;
			end
			SEL_IRQ: begin
				wr_irq = mem_wr;
				rd_mux = rd_irq;
			end
			default: ;
		endcase
	end

	// return stage, holds while no read
	always_ff @(posedge CLK) begin
		if (!RSTb)
			rdata <= '0;
		else if (mem_rd)
			rdata <= rd_mux;
	end

	assign irq_src[IRQ_GPIO] = gpio_int;
	assign irq_src[IRQ_UART] = tx_done;
	assign irq_src[IRQ_PWM] = period_wrap;

	uart_tx u_uart (
		.CLK(CLK), .RSTb(RSTb), .acc(acc), .wr(wr_uart), .rdata(rd_uart),
		.uart_tx(uart_tx), .tx_done(tx_done)
	);

	gpio u_gpio (
		.CLK(CLK), .RSTb(RSTb), .acc(acc), .wr(wr_gpio), .rdata(rd_gpio),
		.gpio_out(gpio_out), .gpio_in(gpio_in), .gpio_int(gpio_int)
	);

	pwm_led u_pwm (
		.CLK(CLK), .RSTb(RSTb), .acc(acc), .wr(wr_pwm), .rdata(rd_pwm),
		.led_r(led_r), .led_g(led_g), .led_b(led_b), .period_wrap(period_wrap)
	);

	interrupt_controller u_irq (
		.CLK(CLK), .RSTb(RSTb), .acc(acc), .wr(wr_irq), .rdata(rd_irq),
		.sources(irq_src), .irq(irq), .interrupt(interrupt)
	);

	a_one_strobe: assert property (@(posedge CLK) disable iff (!RSTb)
		$onehot0({wr_uart, wr_gpio, wr_pwm, wr_irq}));

endmodule

/* tb_clock.sv */
// clock and reset for the testbench
// reset is held low for RESET_CYCLES rising edges, then released after the edge
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 10
) (
	output logic CLK,
	output logic RSTb
);
	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	initial begin
		RSTb = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#2 RSTb = 1'b1;
	end

endmodule

/* tb_port_controller.sv */
// testbench for the IO port controller
// inputs change 2 ns after the rising edge, outputs are sampled on the falling edge
// or 2 ns after the rising edge
`timescale 1ns/1ns

module tb_port_controller;
	import io_pkg::*;

	logic CLK;
	logic RSTb;
	logic [ADDR_BITS-1:0] addr;
	logic [DATA_BITS-1:0] wdata;
	logic mem_wr;
	logic mem_rd;
	logic [DATA_BITS-1:0] rdata;
	logic [GPIO_IN_BITS-1:0] gpio_in;
	logic [GPIO_OUT_BITS-1:0] gpio_out;
	logic led_r;
	logic led_g;
	logic led_b;
	logic uart_tx;
	logic [IRQ_COUNT-1:0] irq;
	logic interrupt;

	int errors = 0;
	int frames = 0;
	logic [31:0] lcg_state = 32'd74024;
	logic [7:0] expected_bytes[$];

	tb_clock #(.PERIOD(20), .RESET_CYCLES(10)) u_clock (.CLK(CLK), .RSTb(RSTb));

	port_controller DUT (
		.CLK(CLK), .RSTb(RSTb), .addr(addr), .wdata(wdata), .mem_wr(mem_wr),
		.mem_rd(mem_rd), .rdata(rdata), .gpio_in(gpio_in), .gpio_out(gpio_out),
		.led_r(led_r), .led_g(led_g), .led_b(led_b), .uart_tx(uart_tx),
		.irq(irq), .interrupt(interrupt)
	);

	function automatic logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	// value a register reads back after a write of data
	function automatic logic [15:0] expected_readback(logic [3:0] sel, logic [3:0] off,
			logic [15:0] data);
		if (sel == SEL_GPIO && off == REG_GPIO_OUT)
			return data & 16'h000f;
		if (sel == SEL_GPIO && off == REG_GPIO_MASK)
			return data & 16'h003f;
		if (sel == SEL_PWM && off <= 4'd2)
			return data & 16'h00ff;
		return 16'h0000;   // unmapped
	endfunction

	// line level of frame bit idx, start and stop included
	function automatic logic frame_bit(logic [7:0] data, int idx);
		if (idx == 0)
			return 1'b0;
		if (idx == 9)
			return 1'b1;
		return data[idx-1];
	endfunction

	function automatic int pwm_high_count(logic [7:0] duty);
		return int'(duty);   // high for duty cycles out of 256
	endfunction

	function automatic logic [2:0] expected_irq(logic [2:0] pending, logic [2:0] enable);
		return pending & enable;
	endfunction

	task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s expected 0x%0h actual 0x%0h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic fail_timeout(string what);
		$display("timeout while waiting for %s", what);
		errors++;
		$display("errors: %0d", errors);
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	task automatic wait_cycles(int n);
		repeat (n) @(posedge CLK);
		#2;
	endtask

	task automatic bus_write(logic [15:0] a, logic [15:0] d);
		@(posedge CLK);
		#2;
		addr = a;
		wdata = d;
		mem_wr = 1'b1;
		@(posedge CLK);
		#2;
		mem_wr = 1'b0;
	endtask

	task automatic bus_read(logic [15:0] a, output logic [15:0] d);
		@(posedge CLK);
		#2;
		addr = a;
		mem_rd = 1'b1;
		@(posedge CLK);   // return stage registers here
		#2;
		mem_rd = 1'b0;
		d = rdata;
	endtask

	task automatic wait_uart_idle();
		logic [15:0] st;
		int n;
		n = 0;
		st = 16'h0001;
		while (st[0]) begin
			bus_read({SEL_UART, 8'h00, REG_UART_STATUS}, st);
			n++;
			if (n > 400)
				fail_timeout("UART status to clear busy");
		end
	endtask

	task automatic wait_wrap();
		int n;
		n = 0;
		@(negedge CLK);
		while (!DUT.period_wrap) begin
			@(negedge CLK);
			n++;
			if (n > 600)
				fail_timeout("PWM period wrap");
		end
	endtask

	// frame receiver, samples at bit centres
	initial begin
		logic [7:0] got;
		logic [7:0] exp_byte;
		logic [9:0] line;
		forever begin
			@(negedge CLK);
			if (RSTb === 1'b1 && uart_tx === 1'b0) begin
				repeat (CLKS_PER_BIT / 2 - 1) @(negedge CLK);
				line[0] = uart_tx;
				for (int i = 1; i < 10; i++) begin
					repeat (CLKS_PER_BIT) @(negedge CLK);
					line[i] = uart_tx;
				end
				got = line[8:1];
				frames++;
				if (expected_bytes.size() == 0) begin
					$display("UART sent a frame 0x%0h that was never expected", got);
					errors++;
				end else begin
					exp_byte = expected_bytes.pop_front();
					for (int i = 0; i < 10; i++)
						check("uart frame bit", frame_bit(exp_byte, i), line[i]);
					check("uart byte", exp_byte, got);
				end
			end
		end
	end

	initial begin
		logic [15:0] v;
		logic [15:0] d;
		logic [15:0] wr_val[5];
		logic [15:0] a_list[5];
		logic [5:0] mask;
		logic [2:0] pend;
		int cnt_r;
		int cnt_g;
		int cnt_b;
		int n;
		addr = '0;
		wdata = '0;
		mem_wr = 1'b0;
		mem_rd = 1'b0;
		gpio_in = '0;
		n = 0;
		while (RSTb !== 1'b1) begin
			@(posedge CLK);
			n++;
			if (n > 50)
				fail_timeout("reset release");
		end
		#2;
		check("reset rdata", 16'h0, rdata);
		check("reset uart_tx", 1'b1, uart_tx);
		check("reset irq", 3'b000, {interrupt, irq} != 0);

		// register map
		a_list = '{16'h1000, 16'h1002, 16'h2000, 16'h2001, 16'h2002};
		for (int i = 0; i < 5; i++) begin
			wr_val[i] = lcg_next();
			bus_write(a_list[i], wr_val[i]);
		end
		for (int i = 0; i < 5; i++) begin
			bus_read(a_list[i], d);
			check("register readback",
				expected_readback(a_list[i][15:12], a_list[i][3:0], wr_val[i]), d);
		end
		check("gpio_out pins", wr_val[0][3:0], gpio_out);
		mask = wr_val[1][5:0];
		bus_write(16'h5000, lcg_next());
		bus_write(16'h9000, lcg_next());
		bus_read(16'h5000, d);
		check("unmapped 0x5000", 16'h0, d);
		bus_read(16'h9000, d);
		check("unmapped 0x9000", 16'h0, d);
		bus_read(16'h1000, d);
		check("gpio out after unmapped write", wr_val[0] & 16'h000f, d);

		// GPIO input path through the synchronizer
		for (int i = 0; i < 6; i++) begin
			v = lcg_next();
			gpio_in = v[GPIO_IN_BITS-1:0];
			wait_cycles(2);
			check("gpio_int pin", gpio_int_of(gpio_in, mask), DUT.gpio_int);
			bus_read({SEL_GPIO, 8'h00, REG_GPIO_IN}, d);
			check("gpio input readback", {10'h0, gpio_in}, d);
		end

		// PWM high counts over one full period
		for (int k = 0; k < 4; k++) begin
			wr_val[0] = lcg_next() & 16'h00ff;
			wr_val[1] = lcg_next() & 16'h00ff;
			wr_val[2] = (k == 0) ? 16'h0 : (lcg_next() & 16'h00ff);
			bus_write({SEL_PWM, 8'h00, REG_PWM_R}, wr_val[0]);
			bus_write({SEL_PWM, 8'h00, REG_PWM_G}, wr_val[1]);
			bus_write({SEL_PWM, 8'h00, REG_PWM_B}, wr_val[2]);
			cnt_r = 0;
			cnt_g = 0;
			cnt_b = 0;
			repeat (256) begin
				@(negedge CLK);
				cnt_r += led_r;
				cnt_g += led_g;
				cnt_b += led_b;
			end
			check("pwm red count", pwm_high_count(wr_val[0][7:0]), cnt_r);
			check("pwm green count", pwm_high_count(wr_val[1][7:0]), cnt_g);
			check("pwm blue count", pwm_high_count(wr_val[2][7:0]), cnt_b);
		end

		// UART bytes, polling status before each write
		for (int i = 0; i < 4; i++) begin
			v = lcg_next() & 16'h00ff;
			wait_uart_idle();
			expected_bytes.push_back(v[7:0]);
			bus_write({SEL_UART, 8'h00, REG_UART_DATA}, v);
		end
		wait_uart_idle();
		v = lcg_next() & 16'h00ff;
		expected_bytes.push_back(v[7:0]);
		bus_write({SEL_UART, 8'h00, REG_UART_DATA}, v);
		wait_cycles(5);
		bus_write({SEL_UART, 8'h00, REG_UART_DATA}, ~v);   // busy, must be dropped
		wait_uart_idle();
		wait_cycles(200);
		check("uart frames sent", 5, frames);
		check("uart queue drained", 0, expected_bytes.size());

		// interrupts
		gpio_in = '0;
		bus_write({SEL_GPIO, 8'h00, REG_GPIO_MASK}, 16'h0001);
		bus_write({SEL_IRQ, 8'h00, REG_IRQ_ENABLE}, 16'h0007);
		wait_cycles(3);
		bus_write({SEL_IRQ, 8'h00, REG_IRQ_PENDING}, 16'h0007);
		gpio_in = 6'h01;
		expected_bytes.push_back(8'h5a);
		bus_write({SEL_UART, 8'h00, REG_UART_DATA}, 16'h005a);
		wait_uart_idle();
		wait_wrap();
		wait_cycles(3);
		bus_read({SEL_IRQ, 8'h00, REG_IRQ_PENDING}, d);
		check("irq pending all", 16'h0007, d);
		check("irq outputs all", expected_irq(3'b111, 3'b111), irq);
		check("interrupt all", 1'b1, interrupt);
		wait_wrap();
		bus_write({SEL_IRQ, 8'h00, REG_IRQ_PENDING}, 16'h0007);
		wait_cycles(1);
		bus_read({SEL_IRQ, 8'h00, REG_IRQ_PENDING}, d);
		check("irq pending cleared", 16'h0000, d);
		check("irq after clear", expected_irq(3'b000, 3'b111), irq);
		check("interrupt after clear", 1'b0, interrupt);
		bus_write({SEL_IRQ, 8'h00, REG_IRQ_ENABLE}, 16'h0003);   // mask the PWM wrap
		wait_wrap();
		wait_cycles(3);
		bus_read({SEL_IRQ, 8'h00, REG_IRQ_PENDING}, d);
		pend = 3'b100;   // gpio level and uart stay quiet, only the wrap is new
		check("pwm pending while masked", {13'h0, pend}, d);
		check("irq with pwm masked", expected_irq(pend, 3'b011), irq);
		check("interrupt with pwm masked", |expected_irq(pend, 3'b011), interrupt);

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	function automatic logic gpio_int_of(logic [5:0] pins, logic [5:0] m);
		return |(pins & m);   // level interrupt from the masked pins
	endfunction

endmodule

/* files.f */
io_pkg.sv
gpio.sv
pwm_led.sv
uart_tx.sv
interrupt_controller.sv
port_controller.sv
tb_clock.sv
tb_port_controller.sv

/* Bender.yml */
package:
  name: io_port_controller

sources:
  - io_pkg.sv
  - gpio.sv
  - pwm_led.sv
  - uart_tx.sv
  - interrupt_controller.sv
  - port_controller.sv
  - target: test
    files:
      - tb_clock.sv
      - tb_port_controller.sv
